/* src/snoop_pkg.sv */
package snoop_pkg;

  // cache geometry
  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumSets     = 16;
  localparam int unsigned LineWidth   = 128;
  localparam int unsigned BeatWidth   = 64;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned OffsetWidth = 4;
  localparam int unsigned IndexWidth  = 4;
  localparam int unsigned TagWidth    = 24;

  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [IndexWidth-1:0] index_t;
  typedef logic [TagWidth-1:0]   tag_t;
  typedef logic [NumWays-1:0]    way_vec_t;
  typedef logic [LineWidth-1:0]  line_t;
  typedef logic [BeatWidth-1:0]  beat_t;

  // ACE snoop codes, other values are answered with error
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_INVALID = 4'b1001
  } snoop_op_t;

  typedef struct packed {
    addr_t     addr;
    snoop_op_t snoop;
  } ac_req_t;

  // data_transfer sits in bit 0 as on the ACE CRRESP bus
  typedef struct packed {
    logic is_shared;
    logic pass_dirty;
    logic error;
    logic data_transfer;
  } cr_resp_t;

  typedef struct packed {
    beat_t data;
    logic  last;
  } cd_beat_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic shared;
  } line_flags_t;

  typedef struct packed {
    addr_t addr;
    line_t data;
    logic  dirty;
    logic  shared;
  } fill_req_t;

  // a request is active when any way is selected
  typedef struct packed {
    way_vec_t    way_sel;
    logic        we;
    index_t      index;
    tag_t        tag;
    line_flags_t wflags;
    line_flags_t wflags_en;
    line_t       wdata;
    logic        wdata_en;
  } array_req_t;

  typedef struct packed {
    logic                      fill_gnt;
    logic                      snoop_gnt;
    way_vec_t                  hit;
    way_vec_t                  dirty;
    way_vec_t                  shared;
    way_vec_t                  invalid;
    line_t [NumWays-1:0]       data;
  } array_rsp_t;

  // line address of a completed ReadShared update
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } readshared_done_t;

endpackage

/* src/dcache_array.sv */
module dcache_array (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  snoop_pkg::array_req_t fill_req_i,
  input  snoop_pkg::array_req_t snoop_req_i,
  input  logic                  fill_busy_i,
  output snoop_pkg::array_rsp_t rsp_o
);

  snoop_pkg::tag_t        tag_mem_q  [snoop_pkg::NumSets][snoop_pkg::NumWays];
  snoop_pkg::line_flags_t flag_mem_q [snoop_pkg::NumSets][snoop_pkg::NumWays];
  snoop_pkg::line_t       data_mem_q [snoop_pkg::NumSets][snoop_pkg::NumWays];

  logic                  fill_gnt;
  logic                  snoop_gnt;
  logic                  any_gnt;
  snoop_pkg::array_req_t sel_req;

  // set snapshot taken at the granted edge
  snoop_pkg::index_t                                rd_index_q;
  snoop_pkg::tag_t                                  rd_tag_q;
  snoop_pkg::tag_t                                  rd_tags_q [snoop_pkg::NumWays];
  snoop_pkg::line_flags_t [snoop_pkg::NumWays-1:0] rd_flags_q;

  // fill port first, snoop port also waits while a fill is in flight
  assign fill_gnt  = |fill_req_i.way_sel;
  assign snoop_gnt = (|snoop_req_i.way_sel) && !fill_busy_i && !fill_gnt;
  assign any_gnt   = fill_gnt || snoop_gnt;
  assign sel_req   = fill_gnt ? fill_req_i : snoop_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_index_q <= '0;
      rd_flags_q <= '0;
    end else if (any_gnt) begin
      rd_index_q <= sel_req.index;
      for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
        rd_flags_q[w] <= flag_mem_q[sel_req.index][w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      rd_tag_q <= sel_req.tag;
      for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
        rd_tags_q[w] <= tag_mem_q[sel_req.index][w];
      end
    end
  end

  // masked flag update, all lines invalid out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned s = 0; s < snoop_pkg::NumSets; s++) begin
        for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
          flag_mem_q[s][w] <= '0;
        end
      end
    end else if (any_gnt && sel_req.we) begin
      for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
        if (sel_req.way_sel[w]) begin
          flag_mem_q[sel_req.index][w] <= snoop_pkg::line_flags_t'(
              (flag_mem_q[sel_req.index][w] & ~sel_req.wflags_en) |
              (sel_req.wflags & sel_req.wflags_en));
        end
      end
    end
  end

  // tag goes in together with the line data
  always_ff @(posedge clk_i) begin
    if (any_gnt && sel_req.we && sel_req.wdata_en) begin
      for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
        if (sel_req.way_sel[w]) begin
          tag_mem_q[sel_req.index][w]  <= sel_req.tag;
          data_mem_q[sel_req.index][w] <= sel_req.wdata;
        end
      end
    end
  end

  always_comb begin
    rsp_o.fill_gnt  = fill_gnt;
    rsp_o.snoop_gnt = snoop_gnt;
    for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
      rsp_o.hit[w]     = rd_flags_q[w].valid && (rd_tags_q[w] == rd_tag_q);
      rsp_o.dirty[w]   = rd_flags_q[w].valid && rd_flags_q[w].dirty;
      rsp_o.shared[w]  = rd_flags_q[w].valid && rd_flags_q[w].shared;
      rsp_o.invalid[w] = !rd_flags_q[w].valid;
      rsp_o.data[w]    = data_mem_q[rd_index_q][w];
    end
  end

  // a tag is never stored twice in one set
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rsp_o.hit))
    else $error("multiple ways hit in set %0d", rd_index_q);

endmodule

/* src/line_fill_ctrl.sv */
module line_fill_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fill_valid_i,
  input  snoop_pkg::fill_req_t  fill_i,
  output logic                  fill_ready_o,
  output snoop_pkg::array_req_t arr_req_o,
  input  snoop_pkg::array_rsp_t arr_rsp_i,
  output logic                  fill_busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WRITE
  } state_t;

  state_t                                 state_d, state_q;
  logic [$clog2(snoop_pkg::NumWays)-1:0]  victim_d, victim_q;
  snoop_pkg::way_vec_t                    first_invalid;
  snoop_pkg::way_vec_t                    write_way;

  // lowest invalid way, scanned from the top so way 0 wins
  always_comb begin
    first_invalid = '0;
    for (int w = snoop_pkg::NumWays - 1; w >= 0; w--) begin
      if (arr_rsp_i.invalid[w]) begin
        first_invalid = snoop_pkg::way_vec_t'(1) << w;
      end
    end
  end

  assign write_way = (|arr_rsp_i.hit)   ? arr_rsp_i.hit :
                     (|first_invalid)   ? first_invalid :
                     snoop_pkg::way_vec_t'(1) << victim_q;

  assign fill_busy_o = (state_q != IDLE);

  always_comb begin
    state_d      = state_q;
    victim_d     = victim_q;
    fill_ready_o = 1'b0;

    // payload is held by the valid rule until the ready in WRITE
    arr_req_o           = '0;
    arr_req_o.index     = fill_i.addr[snoop_pkg::OffsetWidth +: snoop_pkg::IndexWidth];
    arr_req_o.tag       = fill_i.addr[snoop_pkg::OffsetWidth + snoop_pkg::IndexWidth +:
                                      snoop_pkg::TagWidth];
    arr_req_o.wflags    = '{valid: 1'b1, dirty: fill_i.dirty, shared: fill_i.shared};
    arr_req_o.wflags_en = '1;
    arr_req_o.wdata     = fill_i.data;

    unique case (state_q)
      IDLE: begin
        if (fill_valid_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        arr_req_o.way_sel = '1;
        if (arr_rsp_i.fill_gnt) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        arr_req_o.way_sel  = write_way;
        arr_req_o.we       = 1'b1;
        arr_req_o.wdata_en = 1'b1;
        if (arr_rsp_i.fill_gnt) begin
          fill_ready_o = 1'b1;
          state_d      = IDLE;
          // counter moves only when a valid line was replaced
          if (!(|arr_rsp_i.hit) && !(|first_invalid)) begin
            victim_d = victim_q + 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      victim_q <= '0;
    end else begin
      state_q  <= state_d;
      victim_q <= victim_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      arr_req_o.we && arr_rsp_i.fill_gnt |-> $onehot(arr_req_o.way_sel))
    else $error("fill write does not select exactly one way");

endmodule

/* src/snoop_cache_ctrl.sv */
module snoop_cache_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // AC channel
  input  logic                        ac_valid_i,
  input  snoop_pkg::ac_req_t          ac_i,
  output logic                        ac_ready_o,
  // CR channel
  output logic                        cr_valid_o,
  output snoop_pkg::cr_resp_t         cr_o,
  input  logic                        cr_ready_i,
  // CD channel
  output logic                        cd_valid_o,
  output snoop_pkg::cd_beat_t         cd_o,
  input  logic                        cd_ready_i,
  // cache array
  output snoop_pkg::array_req_t       arr_req_o,
  input  snoop_pkg::array_rsp_t       arr_rsp_i,
  output logic                        invalidate_o,
  output snoop_pkg::readshared_done_t readshared_done_o,
  output logic                        busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    EVAL_FLAGS,
    UPDATE_SHARED,
    INVALIDATE,
    SEND_CR,
    SEND_CD
  } state_t;

  state_t               state_d, state_q;
  snoop_pkg::addr_t     addr_d, addr_q;
  snoop_pkg::snoop_op_t op_d, op_q;
  snoop_pkg::cr_resp_t  cr_d, cr_q;
  snoop_pkg::way_vec_t  hit_d, hit_q;
  snoop_pkg::line_t     line_d, line_q;
  logic                 word_sel_d, word_sel_q;

  snoop_pkg::line_t     hit_line;
  logic                 dirty;
  logic                 shared;

  always_comb begin
    hit_line = '0;
    for (int unsigned w = 0; w < snoop_pkg::NumWays; w++) begin
      if (arr_rsp_i.hit[w]) begin
        hit_line = arr_rsp_i.data[w];
      end
    end
  end

  assign dirty  = |(arr_rsp_i.dirty & arr_rsp_i.hit);
  assign shared = |(arr_rsp_i.shared & arr_rsp_i.hit);
  assign busy_o = (state_q != IDLE);

  always_comb begin
    state_d    = state_q;
    addr_d     = addr_q;
    op_d       = op_q;
    cr_d       = cr_q;
    hit_d      = hit_q;
    line_d     = line_q;
    word_sel_d = word_sel_q;

    ac_ready_o   = 1'b0;
    cr_valid_o   = 1'b0;
    cr_o         = '0;
    cd_valid_o   = 1'b0;
    cd_o         = '0;
    invalidate_o = 1'b0;

    readshared_done_o.valid = 1'b0;
    readshared_done_o.addr  = {addr_q[snoop_pkg::AddrWidth-1:snoop_pkg::OffsetWidth],
                               {snoop_pkg::OffsetWidth{1'b0}}};

    // read of the whole set unless a write state overrides it
    arr_req_o       = '0;
    arr_req_o.index = addr_q[snoop_pkg::OffsetWidth +: snoop_pkg::IndexWidth];
    arr_req_o.tag   = addr_q[snoop_pkg::OffsetWidth + snoop_pkg::IndexWidth +:
                             snoop_pkg::TagWidth];

    unique case (state_q)
      IDLE: begin
        cr_d       = '0;
        word_sel_d = 1'b0;
        if (ac_valid_i) begin
          ac_ready_o = 1'b1;
          addr_d     = ac_i.addr;
          op_d       = ac_i.snoop;
          case (ac_i.snoop)
            snoop_pkg::READ_ONCE,
            snoop_pkg::READ_SHARED,
            snoop_pkg::READ_UNIQUE,
            snoop_pkg::CLEAN_INVALID: state_d = WAIT_GNT;
            default: begin
              cr_d.error = 1'b1;
              state_d    = SEND_CR;
            end
          endcase
        end
      end

      WAIT_GNT: begin
        arr_req_o.way_sel = '1;
        if (arr_rsp_i.snoop_gnt) begin
          state_d = EVAL_FLAGS;
        end
      end

      EVAL_FLAGS: begin
        // request stays up so the set is not taken in between
        arr_req_o.way_sel = '1;
        hit_d  = arr_rsp_i.hit;
        line_d = hit_line;
        cr_d   = '0;
        state_d = SEND_CR;
        if (|arr_rsp_i.hit) begin
          cr_d.data_transfer = 1'b1;
          case (op_q)
            snoop_pkg::READ_ONCE: cr_d.is_shared = shared;
            snoop_pkg::READ_SHARED: begin
              cr_d.is_shared = 1'b1;
              state_d        = UPDATE_SHARED;
            end
            snoop_pkg::READ_UNIQUE: begin
              cr_d.pass_dirty = dirty;
              state_d         = INVALIDATE;
            end
            default: begin
              // CleanInvalid only moves data that memory lacks
              cr_d.data_transfer = dirty;
              cr_d.pass_dirty    = dirty;
              state_d            = INVALIDATE;
            end
          endcase
        end
      end

      UPDATE_SHARED: begin
        arr_req_o.way_sel          = hit_q;
        arr_req_o.we               = 1'b1;
        arr_req_o.wflags.shared    = 1'b1;
        arr_req_o.wflags_en.shared = 1'b1;
        if (arr_rsp_i.snoop_gnt) begin
          readshared_done_o.valid = 1'b1;
          state_d                 = SEND_CR;
        end
      end

      INVALIDATE: begin
        arr_req_o.way_sel   = hit_q;
        arr_req_o.we        = 1'b1;
        arr_req_o.wflags_en = '1;
        invalidate_o        = arr_rsp_i.snoop_gnt;
        if (arr_rsp_i.snoop_gnt) begin
          state_d = SEND_CR;
        end
      end

      SEND_CR: begin
        cr_valid_o = 1'b1;
        cr_o       = cr_q;
        if (cr_ready_i) begin
          state_d = cr_q.data_transfer ? SEND_CD : IDLE;
        end
      end

      SEND_CD: begin
        cd_valid_o = 1'b1;
        cd_o.data  = word_sel_q ? line_q[snoop_pkg::LineWidth-1:snoop_pkg::BeatWidth]
                                : line_q[snoop_pkg::BeatWidth-1:0];
        cd_o.last  = word_sel_q;
        if (cd_ready_i) begin
          word_sel_d = !word_sel_q;
          if (word_sel_q) begin
            state_d = IDLE;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      addr_q     <= '0;
      op_q       <= snoop_pkg::READ_ONCE;
      cr_q       <= '0;
      hit_q      <= '0;
      word_sel_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      addr_q     <= addr_d;
      op_q       <= op_d;
      cr_q       <= cr_d;
      hit_q      <= hit_d;
      word_sel_q <= word_sel_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      cr_valid_o && !cr_ready_i |=> cr_valid_o && $stable(cr_o))
    else $error("CR dropped or changed before ready");

  // data beats only after an accepted CR that announced them
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(cd_valid_o) |-> $past(cr_valid_o && cr_ready_i && cr_o.data_transfer))
    else $error("CD beat without a preceding dataTransfer response");

endmodule

/* src/snoop_cache_top.sv */
module snoop_cache_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // snoop channels
  input  logic                        ac_valid_i,
  input  snoop_pkg::ac_req_t          ac_i,
  output logic                        ac_ready_o,
  output logic                        cr_valid_o,
  output snoop_pkg::cr_resp_t         cr_o,
  input  logic                        cr_ready_i,
  output logic                        cd_valid_o,
  output snoop_pkg::cd_beat_t         cd_o,
  input  logic                        cd_ready_i,
  // line fill port
  input  logic                        fill_valid_i,
  input  snoop_pkg::fill_req_t        fill_i,
  output logic                        fill_ready_o,
  // state side events
  output logic                        invalidate_o,
  output snoop_pkg::readshared_done_t readshared_done_o,
  output logic                        busy_o
);

  snoop_pkg::array_req_t fill_arr_req;
  snoop_pkg::array_req_t snoop_arr_req;
  snoop_pkg::array_rsp_t arr_rsp;
  logic                  fill_busy;

  line_fill_ctrl line_fill_ctrl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fill_valid_i (fill_valid_i),
    .fill_i       (fill_i),
    .fill_ready_o (fill_ready_o),
    .arr_req_o    (fill_arr_req),
    .arr_rsp_i    (arr_rsp),
    .fill_busy_o  (fill_busy)
  );

  snoop_cache_ctrl snoop_cache_ctrl_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ac_valid_i        (ac_valid_i),
    .ac_i              (ac_i),
    .ac_ready_o        (ac_ready_o),
    .cr_valid_o        (cr_valid_o),
    .cr_o              (cr_o),
    .cr_ready_i        (cr_ready_i),
    .cd_valid_o        (cd_valid_o),
    .cd_o              (cd_o),
    .cd_ready_i        (cd_ready_i),
    .arr_req_o         (snoop_arr_req),
    .arr_rsp_i         (arr_rsp),
    .invalidate_o      (invalidate_o),
    .readshared_done_o (readshared_done_o),
    .busy_o            (busy_o)
  );

  dcache_array dcache_array_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fill_req_i  (fill_arr_req),
    .snoop_req_i (snoop_arr_req),
    .fill_busy_i (fill_busy),
    .rsp_o       (arr_rsp)
  );

endmodule

/* dv/tb_snoop_cache.sv */
module tb_snoop_cache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned WaitLimit = 64;

  // one row of the stimulus table
  // data holds the fill data or the expected line
  typedef struct packed {
    logic                is_fill;
    snoop_pkg::addr_t    addr;
    logic [3:0]          snoop;
    snoop_pkg::line_t    data;
    logic                dirty;
    logic                shared;
    snoop_pkg::cr_resp_t exp_cr;
    logic                exp_inval;
    logic                exp_rsd;
  } row_t;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        ac_valid_i;
  snoop_pkg::ac_req_t          ac_i;
  logic                        ac_ready_o;
  logic                        cr_valid_o;
  snoop_pkg::cr_resp_t         cr_o;
  logic                        cr_ready_i;
  logic                        cd_valid_o;
  snoop_pkg::cd_beat_t         cd_o;
  logic                        cd_ready_i;
  logic                        fill_valid_i;
  snoop_pkg::fill_req_t        fill_i;
  logic                        fill_ready_o;
  logic                        invalidate_o;
  snoop_pkg::readshared_done_t readshared_done_o;
  logic                        busy_o;

  row_t             rows[$];
  int               errors;
  int               timeouts;
  // running totals kept by the monitor
  int               inval_seen = 0;
  int               rsd_seen = 0;
  int               beats_seen = 0;
  snoop_pkg::addr_t rsd_addr = '0;

  snoop_cache_top snoop_cache_top_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ac_valid_i        (ac_valid_i),
    .ac_i              (ac_i),
    .ac_ready_o        (ac_ready_o),
    .cr_valid_o        (cr_valid_o),
    .cr_o              (cr_o),
    .cr_ready_i        (cr_ready_i),
    .cd_valid_o        (cd_valid_o),
    .cd_o              (cd_o),
    .cd_ready_i        (cd_ready_i),
    .fill_valid_i      (fill_valid_i),
    .fill_i            (fill_i),
    .fill_ready_o      (fill_ready_o),
    .invalidate_o      (invalidate_o),
    .readshared_done_o (readshared_done_o),
    .busy_o            (busy_o)
  );

  always #5ns clk_i = ~clk_i;

  // state side pulses and CD handshakes sampled mid cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (invalidate_o) begin
        inval_seen++;
      end
      if (readshared_done_o.valid) begin
        rsd_seen++;
        rsd_addr = readshared_done_o.addr;
      end
      if (cd_valid_o && cd_ready_i) begin
        beats_seen++;
      end
    end
  end

  function automatic snoop_pkg::addr_t line_addr(input snoop_pkg::tag_t tag,
                                                 input snoop_pkg::index_t set);
    return {tag, set, 4'h0};
  endfunction

  // line content that depends on every address bit
  function automatic snoop_pkg::line_t make_line(input snoop_pkg::addr_t a,
                                                 input logic [7:0] gen);
    return {a ^ {4{gen}}, ~a, a + 32'h1357_9bdf, gen, a[23:0]};
  endfunction

  function automatic snoop_pkg::cr_resp_t cr_bits(input logic dt, input logic pd,
                                                  input logic sh, input logic er);
    snoop_pkg::cr_resp_t c;
    c.data_transfer = dt;
    c.pass_dirty    = pd;
    c.is_shared     = sh;
    c.error         = er;
    return c;
  endfunction

  function automatic logic signal_state(input int unsigned sel);
    case (sel)
      0: return ac_ready_o;
      1: return cr_valid_o;
      2: return cd_valid_o;
      3: return fill_ready_o;
      default: return !busy_o;
    endcase
  endfunction

  task automatic finish_run();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("timeout: no %s within %0d cycles at %0t", what, WaitLimit, $time);
    timeouts++;
    finish_run();
  endtask

  task automatic check_value(input string what, input snoop_pkg::line_t got,
                             input snoop_pkg::line_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s mismatch, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic next_drive();
    @(posedge clk_i);
    #1ns;
  endtask

  // returns at the negedge where the selected signal is high
  task automatic wait_for_signal(input int unsigned sel, input string what);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!signal_state(sel) && cnt < WaitLimit) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!signal_state(sel)) begin
      give_up(what);
    end
  endtask

  task automatic add_fill(input snoop_pkg::addr_t a, input logic [7:0] gen,
                          input logic dirty, input logic shared);
    row_t r;
    r = '0;
    r.is_fill = 1'b1;
    r.addr    = a;
    r.data    = make_line(a, gen);
    r.dirty   = dirty;
    r.shared  = shared;
    rows.push_back(r);
  endtask

  task automatic add_snoop(input snoop_pkg::addr_t a, input logic [3:0] code,
                           input snoop_pkg::cr_resp_t cr, input logic [7:0] gen,
                           input logic inval, input logic rsd);
    row_t r;
    r = '0;
    r.addr      = a;
    r.snoop     = code;
    r.data      = make_line(a, gen);
    r.exp_cr    = cr;
    r.exp_inval = inval;
    r.exp_rsd   = rsd;
    rows.push_back(r);
  endtask

  task automatic build_table();
    snoop_pkg::addr_t a, b, c, e, f, g;
    snoop_pkg::addr_t t1, t2, t3, t4, t5;
    a  = line_addr(24'h000100, 4'h1);
    b  = line_addr(24'h000200, 4'h2);
    c  = line_addr(24'h000300, 4'h3);
    e  = line_addr(24'h000400, 4'h4);
    f  = line_addr(24'h000500, 4'h5);
    g  = line_addr(24'h000600, 4'h6);
    t1 = line_addr(24'h001000, 4'h9);
    t2 = line_addr(24'h002000, 4'h9);
    t3 = line_addr(24'h003000, 4'h9);
    t4 = line_addr(24'h004000, 4'h9);
    t5 = line_addr(24'h005000, 4'h9);
    // never filled line
    add_snoop(line_addr(24'h000055, 4'h5), snoop_pkg::READ_ONCE,
              cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h00, 1'b0, 1'b0);
    add_fill(a, 8'h01, 1'b0, 1'b1);
    add_snoop(a, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b1, 1'b0), 8'h01, 1'b0, 1'b0);
    // ReadShared marks the line shared
    add_fill(b, 8'h02, 1'b0, 1'b0);
    add_snoop(b, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h02, 1'b0, 1'b0);
    add_snoop(b, snoop_pkg::READ_SHARED, cr_bits(1'b1, 1'b0, 1'b1, 1'b0), 8'h02, 1'b0, 1'b1);
    add_snoop(b, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b1, 1'b0), 8'h02, 1'b0, 1'b0);
    // CleanInvalid on dirty and on clean lines
    add_fill(c, 8'h03, 1'b1, 1'b0);
    add_snoop(c, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h03, 1'b0, 1'b0);
    add_snoop(c, snoop_pkg::CLEAN_INVALID, cr_bits(1'b1, 1'b1, 1'b0, 1'b0), 8'h03, 1'b1, 1'b0);
    add_snoop(c, snoop_pkg::READ_ONCE, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h03, 1'b0, 1'b0);
    add_fill(e, 8'h04, 1'b0, 1'b0);
    add_snoop(e, snoop_pkg::CLEAN_INVALID, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h04, 1'b1, 1'b0);
    add_snoop(e, snoop_pkg::READ_ONCE, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h04, 1'b0, 1'b0);
    // ReadUnique passes the dirty flag and invalidates
    add_fill(f, 8'h05, 1'b1, 1'b1);
    add_snoop(f, snoop_pkg::READ_UNIQUE, cr_bits(1'b1, 1'b1, 1'b0, 1'b0), 8'h05, 1'b1, 1'b0);
    add_snoop(f, snoop_pkg::CLEAN_INVALID, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h05, 1'b0, 1'b0);
    add_fill(g, 8'h06, 1'b0, 1'b0);
    add_snoop(g, snoop_pkg::READ_UNIQUE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h06, 1'b1, 1'b0);
    add_snoop(g, snoop_pkg::READ_ONCE, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h06, 1'b0, 1'b0);
    // unknown codes leave the line alone
    add_snoop(a, 4'h2, cr_bits(1'b0, 1'b0, 1'b0, 1'b1), 8'h01, 1'b0, 1'b0);
    add_snoop(a, 4'hf, cr_bits(1'b0, 1'b0, 1'b0, 1'b1), 8'h01, 1'b0, 1'b0);
    add_snoop(a, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b1, 1'b0), 8'h01, 1'b0, 1'b0);
    // five tags in set 9 so the fifth replaces way 0
    add_fill(t1, 8'h11, 1'b0, 1'b0);
    add_fill(t2, 8'h12, 1'b0, 1'b0);
    add_fill(t3, 8'h13, 1'b0, 1'b0);
    add_fill(t4, 8'h14, 1'b0, 1'b0);
    add_fill(t5, 8'h15, 1'b0, 1'b0);
    add_snoop(t1, snoop_pkg::READ_ONCE, cr_bits(1'b0, 1'b0, 1'b0, 1'b0), 8'h11, 1'b0, 1'b0);
    add_snoop(t5, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h15, 1'b0, 1'b0);
    add_snoop(t2, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h12, 1'b0, 1'b0);
    // refill of a present tag with new data and flags
    add_fill(t3, 8'h23, 1'b1, 1'b1);
    add_snoop(t3, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b1, 1'b0), 8'h23, 1'b0, 1'b0);
    add_snoop(t4, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h14, 1'b0, 1'b0);
    add_snoop(t5, snoop_pkg::READ_ONCE, cr_bits(1'b1, 1'b0, 1'b0, 1'b0), 8'h15, 1'b0, 1'b0);
    add_snoop(t3, snoop_pkg::CLEAN_INVALID, cr_bits(1'b1, 1'b1, 1'b0, 1'b0), 8'h23, 1'b1, 1'b0);
  endtask

  task automatic fill_line(input row_t r);
    fill_valid_i  = 1'b1;
    fill_i.addr   = r.addr;
    fill_i.data   = r.data;
    fill_i.dirty  = r.dirty;
    fill_i.shared = r.shared;
    wait_for_signal(3, "fill ready");
    next_drive();
    fill_valid_i = 1'b0;
  endtask

  task automatic run_snoop(input row_t r, input int n);
    snoop_pkg::cr_resp_t cr_seen;
    snoop_pkg::cd_beat_t beat;
    int                  inval_base;
    int                  rsd_base;
    int                  beats_base;
    int unsigned         stall;
    inval_base  = inval_seen;
    rsd_base    = rsd_seen;
    beats_base  = beats_seen;
    ac_valid_i  = 1'b1;
    ac_i.addr   = r.addr;
    ac_i.snoop  = snoop_pkg::snoop_op_t'(r.snoop);
    wait_for_signal(0, "AC ready");
    next_drive();
    ac_valid_i = 1'b0;
    // ready stays low for 0 to 3 cycles of valid
    stall      = $urandom_range(3, 0);
    cr_ready_i = (stall == 0);
    wait_for_signal(1, "CR response");
    if (stall != 0) begin
      repeat (stall) next_drive();
      cr_ready_i = 1'b1;
      @(negedge clk_i);
    end
    cr_seen = cr_o;
    check_value($sformatf("row %0d CR valid", n), snoop_pkg::line_t'(cr_valid_o), 128'd1);
    check_value($sformatf("row %0d busy", n), snoop_pkg::line_t'(busy_o), 128'd1);
    next_drive();
    cr_ready_i = 1'b0;
    check_value($sformatf("row %0d CR bits", n), snoop_pkg::line_t'(cr_seen),
                snoop_pkg::line_t'(r.exp_cr));
    if (cr_seen.data_transfer) begin
      for (int b = 0; b < 2; b++) begin
        stall      = $urandom_range(3, 0);
        cd_ready_i = (stall == 0);
        wait_for_signal(2, "CD beat");
        if (stall != 0) begin
          repeat (stall) next_drive();
          cd_ready_i = 1'b1;
          @(negedge clk_i);
        end
        beat = cd_o;
        next_drive();
        cd_ready_i = 1'b0;
        check_value($sformatf("row %0d CD beat %0d data", n, b), snoop_pkg::line_t'(beat.data),
                    snoop_pkg::line_t'((b == 1) ? r.data[127:64] : r.data[63:0]));
        check_value($sformatf("row %0d CD beat %0d last", n, b), snoop_pkg::line_t'(beat.last),
                    snoop_pkg::line_t'(b == 1));
      end
    end
    wait_for_signal(4, "return of the snoop controller to idle");
    next_drive();
    check_value($sformatf("row %0d CD beat count", n), snoop_pkg::line_t'(beats_seen - beats_base),
                r.exp_cr.data_transfer ? 128'd2 : 128'd0);
    check_value($sformatf("row %0d invalidate pulses", n),
                snoop_pkg::line_t'(inval_seen - inval_base), snoop_pkg::line_t'(r.exp_inval));
    check_value($sformatf("row %0d ReadShared done pulses", n),
                snoop_pkg::line_t'(rsd_seen - rsd_base), snoop_pkg::line_t'(r.exp_rsd));
    if (r.exp_rsd) begin
      check_value($sformatf("row %0d ReadShared done address", n), snoop_pkg::line_t'(rsd_addr),
                  snoop_pkg::line_t'(r.addr));
    end
  endtask

  initial begin
    void'($urandom(49981));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    ac_valid_i   = 1'b0;
    ac_i         = '0;
    cr_ready_i   = 1'b0;
    cd_ready_i   = 1'b0;
    fill_valid_i = 1'b0;
    fill_i       = '0;
    errors       = 0;
    timeouts     = 0;
    build_table();
    repeat (8) @(posedge clk_i);
    #1ns;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("outputs after reset",
                snoop_pkg::line_t'({ac_ready_o, cr_valid_o, cd_valid_o, fill_ready_o,
                                    invalidate_o, readshared_done_o.valid, busy_o}), '0);
    next_drive();
    foreach (rows[i]) begin
      if (rows[i].is_fill) begin
        fill_line(rows[i]);
      end else begin
        run_snoop(rows[i], i);
      end
    end
    finish_run();
  end

endmodule

/* all.f */
src/snoop_pkg.sv
src/dcache_array.sv
src/line_fill_ctrl.sv
src/snoop_cache_ctrl.sv
src/snoop_cache_top.sv
dv/tb_snoop_cache.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv \
  -f all.f \
  --top-module tb_snoop_cache \
  -o tb_snoop_cache

./obj_dir/tb_snoop_cache | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi
